// File: logic/conv_pkg.sv
package conv_pkg;

    //////////////////////////////////////////////////////////////////////
    // array and buffer sizes
    //////////////////////////////////////////////////////////////////////
    localparam int N_PE     = 4;
    localparam int LOG_N_PE = 2;
    localparam int N_BUF    = N_PE;
    localparam int ADDR_RAM = 16;
    localparam int IDX_W    = 16;

    // pe array pipeline depths
    localparam int LAT_MAC      = 2;
    localparam int LAT_ADD_TREE = 2;
    localparam int LAT_FB_ADD   = 1;
    localparam int LAT_NL       = 1;

    typedef struct packed {
        logic [IDX_W-1:0] data_wid;
        logic [IDX_W-1:0] data_hei;
        logic [IDX_W-1:0] data_ch;
        logic [IDX_W-1:0] filter_wid;
        logic [IDX_W-1:0] filter_hei;
        logic [IDX_W-1:0] filter_num;
    } conv_cfg_t;

    typedef struct packed {
        logic [IDX_W-1:0]                 input_size;
        logic [IDX_W-1:0]                 out_wid;
        logic [IDX_W-1:0]                 out_size;
        logic [IDX_W-1:0]                 filter_size;
        logic [IDX_W-1:0]                 fb_full;      // full filter blocks
        logic [IDX_W-1:0]                 cb_full;      // full channel blocks
        logic [IDX_W-1:0]                 fbe;
        logic [IDX_W-1:0]                 cbe;
        logic [LOG_N_PE-1:0]              extra_f;
        logic [N_PE-1:0]                  extra_c_mask;
        logic [N_BUF-1:0][ADDR_RAM-1:0]   kern_base;    // kernels start after the images
        logic [IDX_W-1:0]                 kern_stride;
        logic [IDX_W-1:0]                 win_lat;
        logic [IDX_W-1:0]                 row_period;   // gate period of one input row
    } conv_geom_t;

    typedef struct packed {
        logic [IDX_W-1:0] fb;
        logic [IDX_W-1:0] cb;
        logic             fbe_on;
        logic             cbe_on;
        logic             first_cb;
        logic             last_cb;
    } block_pos_t;

    typedef struct packed {
        logic [N_BUF-1:0]               en;
        logic [N_BUF-1:0][ADDR_RAM-1:0] addr;
    } buf_port_t;

    typedef struct packed {
        logic [N_PE-1:0][N_PE-1:0] shift_filter;   // [filter row][channel column]
        logic [N_PE-1:0][N_PE-1:0] shift_line;
        logic [N_PE-1:0][N_PE-1:0] mac_en;
        logic                      line_buffer_reset;
    } pe_feed_t;

    typedef struct packed {
        logic [N_PE-1:0] feedback_en;
        logic [N_PE-1:0] nl_en;
    } pe_psum_t;

    // filter rows in use for the current block
    function automatic logic [N_PE-1:0] filter_mask(block_pos_t pos, conv_geom_t geom);
        logic [N_PE-1:0] m;
        for (int i = 0; i < N_PE; i++) begin
            m[i] = !pos.fbe_on || (LOG_N_PE'(i) < geom.extra_f);
        end
        return m;
    endfunction

    // channel columns in use for the current block
    function automatic logic [N_PE-1:0] channel_mask(block_pos_t pos, conv_geom_t geom);
        return pos.cbe_on ? geom.extra_c_mask : {N_PE{1'b1}};
    endfunction

endpackage

// File: logic/conv_geometry.sv
`timescale 1ns/1ps

module conv_geometry import conv_pkg::*; (
    input  conv_cfg_t  cfg,
    output conv_geom_t geom
);

    logic [IDX_W-1:0]    out_hei;
    logic [LOG_N_PE-1:0] extra_c;   // channels in the partial channel block

    // stride 1, no padding
    assign out_hei = cfg.data_hei - cfg.filter_hei + 1'b1;
    assign extra_c = cfg.data_ch[LOG_N_PE-1:0];

    always_comb begin
        geom.input_size  = cfg.data_wid * cfg.data_hei;
        geom.out_wid     = cfg.data_wid - cfg.filter_wid + 1'b1;
        geom.out_size    = geom.out_wid * out_hei;
        geom.filter_size = cfg.filter_wid * cfg.filter_hei;

        geom.fb_full = cfg.filter_num >> LOG_N_PE;
        geom.cb_full = cfg.data_ch >> LOG_N_PE;
        geom.extra_f = cfg.filter_num[LOG_N_PE-1:0];
        geom.fbe     = geom.fb_full + IDX_W'(geom.extra_f != '0);
        geom.cbe     = geom.cb_full + IDX_W'(extra_c != '0);

        for (int i = 0; i < N_PE; i++) begin
            geom.extra_c_mask[i] = LOG_N_PE'(i) < extra_c;
        end

        // bank i holds cb_full or cb_full+1 images ahead of its kernels
        for (int b = 0; b < N_BUF; b++) begin
            geom.kern_base[b] = geom.input_size * (geom.cb_full + IDX_W'(geom.extra_c_mask[b]));
        end

        geom.kern_stride = geom.filter_size * cfg.filter_num;
        geom.win_lat     = (cfg.filter_hei - 1'b1) * cfg.data_wid + cfg.filter_wid;
        geom.row_period  = cfg.data_wid;    // out_wid + filter_wid - 1
    end

endmodule

// File: logic/kernel_loader.sv
`timescale 1ns/1ps

module kernel_loader import conv_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  conv_geom_t geom,
    input  block_pos_t pos,
    output logic       done,
    output buf_port_t  buf1_rd,
    output logic [N_PE-1:0][N_PE-1:0] shift_filter
);

    typedef enum logic [1:0] {LD_IDLE, LD_READ, LD_GAP} ld_state_t;

    ld_state_t           state;
    logic [LOG_N_PE-1:0] f_mod;
    logic [LOG_N_PE-1:0] last_f;
    logic [IDX_W-1:0]    kern_idx;
    logic [ADDR_RAM-1:0] kern_off;
    logic [N_PE-1:0]     cmask;
    logic [N_PE-1:0]     sf_mask;    // read banks delayed by one cycle
    logic [LOG_N_PE-1:0] sf_row;

    assign last_f   = pos.fbe_on ? geom.extra_f - 1'b1 : LOG_N_PE'(N_PE - 1);
    assign cmask    = channel_mask(pos, geom);
    // filter number N_PE*fb + f_mod is a plain concatenation
    assign kern_off = geom.kern_stride * pos.cb
                    + geom.filter_size * {pos.fb[IDX_W-LOG_N_PE-1:0], f_mod}
                    + kern_idx;
    assign done = (state == LD_GAP) && (f_mod == last_f);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= LD_IDLE;
            f_mod    <= '0;
            kern_idx <= '0;
            sf_mask  <= '0;
        end else begin
            sf_mask <= (state == LD_READ) ? cmask : '0;
            case (state)
                LD_IDLE: if (start) begin
                    state    <= LD_READ;
                    f_mod    <= '0;
                    kern_idx <= '0;
                end
                LD_READ: begin
                    kern_idx <= kern_idx + 1'b1;
                    if (kern_idx == geom.filter_size - 1'b1) begin
                        state    <= LD_GAP;
                        kern_idx <= '0;
                    end
                end
                default: begin    // control cycle between filters
                    state <= done ? LD_IDLE : LD_READ;
                    f_mod <= f_mod + 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        sf_row <= f_mod;
    end

    always_comb begin
        buf1_rd = '0;
        for (int b = 0; b < N_BUF; b++) begin
            if (state == LD_READ && cmask[b]) begin
                buf1_rd.en[b]   = 1'b1;
                buf1_rd.addr[b] = geom.kern_base[b] + kern_off;
            end
        end
        for (int r = 0; r < N_PE; r++) begin
            shift_filter[r] = (LOG_N_PE'(r) == sf_row) ? sf_mask : '0;
        end
    end

endmodule

// File: logic/image_feeder.sv
`timescale 1ns/1ps

module image_feeder import conv_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  conv_geom_t geom,
    input  block_pos_t pos,
    output buf_port_t  buf1_rd,
    output logic [N_PE-1:0][N_PE-1:0] shift_line,
    output logic [N_PE-1:0][N_PE-1:0] mac_en
);

    logic                rd_on;
    logic [IDX_W-1:0]    rd_idx;     // also the cycle count of the block
    logic                sl_on;
    logic                mac_on;
    logic [ADDR_RAM-1:0] img_base;
    logic [N_PE-1:0]     fmask;
    logic [N_PE-1:0]     cmask;

    assign img_base = geom.input_size * pos.cb;
    assign fmask    = filter_mask(pos, geom);
    assign cmask    = channel_mask(pos, geom);
    // window full from win_lat up to the last pixel
    assign mac_on   = rd_on && (rd_idx >= geom.win_lat);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_on  <= 1'b0;
            rd_idx <= '0;
            sl_on  <= 1'b0;
        end else begin
            sl_on <= rd_on;
            if (start) begin
                rd_on  <= 1'b1;
                rd_idx <= '0;
            end else if (rd_on) begin
                rd_idx <= rd_idx + 1'b1;
                if (rd_idx == geom.input_size - 1'b1) begin
                    rd_on <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        buf1_rd = '0;
        for (int b = 0; b < N_BUF; b++) begin
            if (rd_on && cmask[b]) begin
                buf1_rd.en[b]   = 1'b1;
                buf1_rd.addr[b] = img_base + rd_idx;
            end
        end
    end

    always_comb begin
        for (int r = 0; r < N_PE; r++) begin
            for (int c = 0; c < N_PE; c++) begin
                shift_line[r][c] = sl_on && fmask[r] && cmask[c];
                mac_en[r][c]     = mac_on && fmask[r] && cmask[c];
            end
        end
    end

endmodule

// File: logic/conv_loop_seq.sv
`timescale 1ns/1ps

module conv_loop_seq import conv_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  conv_geom_t geom,
    output block_pos_t pos,
    output logic       stream_start,
    input  logic       stream_done,
    output logic       done,
    output buf_port_t  buf1_rd,
    output pe_feed_t   pe_feed
);

    typedef enum logic [2:0] {ST_IDLE, ST_FB, ST_CB, ST_LOAD, ST_STREAM} seq_state_t;

    seq_state_t       state;
    logic [IDX_W-1:0] fb;
    logic [IDX_W-1:0] cb;
    logic             fbe_on;
    logic             cbe_on;
    logic             load_start;
    logic             load_done;
    buf_port_t        ld_rd;
    buf_port_t        fd_rd;
    logic [N_PE-1:0][N_PE-1:0] shift_filter;
    logic [N_PE-1:0][N_PE-1:0] shift_line;
    logic [N_PE-1:0][N_PE-1:0] mac_en;

    assign load_start   = (state == ST_CB) && (cb != geom.cbe);
    assign stream_start = (state == ST_LOAD) && load_done;
    assign done         = (state == ST_FB) && (fb == geom.fbe);

    //////////////////////////////////////////////////////////////////////
    // filter block loop around channel block loop
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= ST_IDLE;
            fb     <= '0;
            cb     <= '0;
            fbe_on <= 1'b0;
            cbe_on <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: if (start) begin
                    state <= ST_FB;
                    fb    <= '0;
                end
                ST_FB: begin
                    if (done) begin
                        state <= ST_IDLE;
                    end else begin
                        state  <= ST_CB;
                        cb     <= '0;
                        fbe_on <= (fb == geom.fb_full);   // partial block comes last
                    end
                end
                ST_CB: begin
                    if (load_start) begin
                        state  <= ST_LOAD;
                        cbe_on <= (cb == geom.cb_full);
                    end else begin
                        state <= ST_FB;
                        fb    <= fb + 1'b1;
                    end
                end
                ST_LOAD: if (load_done) state <= ST_STREAM;
                default: if (stream_done) begin
                    state <= ST_CB;
                    cb    <= cb + 1'b1;
                end
            endcase
        end
    end

    always_comb begin
        pos.fb       = fb;
        pos.cb       = cb;
        pos.fbe_on   = fbe_on;
        pos.cbe_on   = cbe_on;
        pos.first_cb = (cb == '0);
        pos.last_cb  = (cb == geom.cbe - 1'b1);
    end

    kernel_loader u_loader (
        .clk          (clk),
        .rst          (rst),
        .start        (load_start),
        .geom         (geom),
        .pos          (pos),
        .done         (load_done),
        .buf1_rd      (ld_rd),
        .shift_filter (shift_filter)
    );

    image_feeder u_feeder (
        .clk        (clk),
        .rst        (rst),
        .start      (stream_start),
        .geom       (geom),
        .pos        (pos),
        .buf1_rd    (fd_rd),
        .shift_line (shift_line),
        .mac_en     (mac_en)
    );

    // loader and feeder never read in the same cycle
    assign buf1_rd = ld_rd | fd_rd;

    always_comb begin
        pe_feed.shift_filter      = shift_filter;
        pe_feed.shift_line        = shift_line;
        pe_feed.mac_en            = mac_en;
        pe_feed.line_buffer_reset = (state != ST_STREAM);
    end

endmodule

// File: logic/row_gated_phase.sv
`timescale 1ns/1ps

module row_gated_phase import conv_pkg::*; #(
    parameter int LAT_OFFSET = 0
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  conv_geom_t       geom,
    output logic             active,
    output logic [IDX_W-1:0] index
);

    logic             busy;
    logic [IDX_W-1:0] lat_cnt;
    logic [IDX_W-1:0] gate_cnt;
    logic [IDX_W-1:0] target;
    logic             waiting;

    assign target  = geom.win_lat + IDX_W'(LAT_OFFSET);
    assign waiting = (lat_cnt != target);
    // first out_wid cycles of each row carry valid windows
    assign active  = busy && !waiting && (gate_cnt < geom.out_wid);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy     <= 1'b0;
            lat_cnt  <= '0;
            gate_cnt <= '0;
            index    <= '0;
        end else if (start) begin
            busy     <= 1'b1;
            lat_cnt  <= '0;
            gate_cnt <= '0;
            index    <= '0;
        end else if (busy) begin
            if (waiting) begin
                lat_cnt <= lat_cnt + 1'b1;
            end else begin
                gate_cnt <= (gate_cnt == geom.row_period - 1'b1) ? '0 : gate_cnt + 1'b1;
                if (active) begin
                    index <= index + 1'b1;
                    if (index == geom.out_size - 1'b1) busy <= 1'b0;   // last output
                end
            end
        end
    end

endmodule

// File: logic/psum_path.sv
`timescale 1ns/1ps

module psum_path import conv_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       stream_start,
    input  conv_geom_t geom,
    input  block_pos_t pos,
    output logic       stream_done,
    output buf_port_t  buf2_wr,
    output buf_port_t  buf2_rd,
    output pe_psum_t   pe_psum
);

    logic                wr_active;
    logic                fr_active;
    logic                fe_active;
    logic                nl_active;
    logic [IDX_W-1:0]    wr_index;
    logic [IDX_W-1:0]    fr_index;
    logic [ADDR_RAM-1:0] out_base;
    logic [N_PE-1:0]     fmask;

    assign out_base    = geom.out_size * pos.fb;
    assign fmask       = filter_mask(pos, geom);
    assign stream_done = wr_active && (wr_index == geom.out_size - 1'b1);

    //////////////////////////////////////////////////////////////////////
    // one timer per stage with offsets from the pe array pipeline
    //////////////////////////////////////////////////////////////////////
    row_gated_phase #(.LAT_OFFSET(LAT_MAC + LAT_ADD_TREE + LAT_FB_ADD + LAT_NL)) u_wr (
        .clk (clk), .rst (rst), .start (stream_start), .geom (geom),
        .active (wr_active), .index (wr_index)
    );

    row_gated_phase #(.LAT_OFFSET(LAT_MAC + LAT_ADD_TREE - 1)) u_fb_rd (
        .clk (clk), .rst (rst), .start (stream_start), .geom (geom),
        .active (fr_active), .index (fr_index)
    );

    row_gated_phase #(.LAT_OFFSET(LAT_MAC + LAT_ADD_TREE)) u_fb_en (
        .clk (clk), .rst (rst), .start (stream_start), .geom (geom),
        .active (fe_active), .index ()
    );

    row_gated_phase #(.LAT_OFFSET(LAT_MAC + LAT_ADD_TREE + LAT_FB_ADD)) u_nl (
        .clk (clk), .rst (rst), .start (stream_start), .geom (geom),
        .active (nl_active), .index ()
    );

    always_comb begin
        buf2_wr = '0;
        buf2_rd = '0;
        for (int b = 0; b < N_BUF; b++) begin
            if (wr_active && fmask[b]) begin
                buf2_wr.en[b]   = 1'b1;
                buf2_wr.addr[b] = out_base + wr_index;
            end
            if (fr_active && fmask[b] && !pos.first_cb) begin   // no partial sum yet on cb 0
                buf2_rd.en[b]   = 1'b1;
                buf2_rd.addr[b] = out_base + fr_index;
            end
        end
        pe_psum.feedback_en = (fe_active && !pos.first_cb) ? fmask : '0;
        pe_psum.nl_en       = (nl_active && pos.last_cb) ? fmask : '0;
    end

endmodule

// File: logic/conv_ctrl_top.sv
`timescale 1ns/1ps

module conv_ctrl_top import conv_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    input  conv_cfg_t cfg,
    output logic      done,
    output buf_port_t buf1_rd,
    output buf_port_t buf2_wr,
    output buf_port_t buf2_rd,
    output pe_feed_t  pe_feed,
    output pe_psum_t  pe_psum
);

    conv_geom_t geom;
    block_pos_t pos;
    logic       stream_start;
    logic       stream_done;

    conv_geometry u_geom (
        .cfg  (cfg),
        .geom (geom)
    );

    conv_loop_seq u_seq (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .geom         (geom),
        .pos          (pos),
        .stream_start (stream_start),
        .stream_done  (stream_done),
        .done         (done),
        .buf1_rd      (buf1_rd),
        .pe_feed      (pe_feed)
    );

    psum_path u_psum (
        .clk          (clk),
        .rst          (rst),
        .stream_start (stream_start),
        .geom         (geom),
        .pos          (pos),
        .stream_done  (stream_done),
        .buf2_wr      (buf2_wr),
        .buf2_rd      (buf2_rd),
        .pe_psum      (pe_psum)
    );

endmodule

// File: testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;    // 100 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// File: testbench/conv_ctrl_tb.sv
`timescale 1ns/1ps

module conv_ctrl_tb import conv_pkg::*; ();

    localparam int N_CFG = 8;

    logic      clk;
    logic      rst;
    logic      start;
    conv_cfg_t cfg;
    logic      done;
    buf_port_t buf1_rd;
    buf_port_t buf2_wr;
    buf_port_t buf2_rd;
    pe_feed_t  pe_feed;
    pe_psum_t  pe_psum;

    int        seed;
    int        errors;
    int        budget_cycles;
    int        done_cnt;
    conv_cfg_t cfgs [N_CFG];

    // expected {bank, addr} beats in issue order
    logic [31:0] kq[$];
    logic [31:0] iq[$];
    logic [31:0] wq[$];
    logic [31:0] rq[$];
    int exp_sf;
    int exp_sl;
    int exp_mac;
    int exp_fe;
    int exp_nl;
    int got_sf;
    int got_sl;
    int got_mac;
    int got_fe;
    int got_nl;

    tb_clock u_clk (.clk (clk), .rst (rst));

    conv_ctrl_top dut0 (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .cfg     (cfg),
        .done    (done),
        .buf1_rd (buf1_rd),
        .buf2_wr (buf2_wr),
        .buf2_rd (buf2_rd),
        .pe_feed (pe_feed),
        .pe_psum (pe_psum)
    );

    function automatic int pick(input int n);
        return int'({$random(seed)} % n);
    endfunction

    function automatic conv_cfg_t make_cfg(input int ch, input int fn);
        conv_cfg_t c;
        int fw;
        int fh;
        fw = 1 + pick(3);
        fh = 1 + pick(3);
        c.filter_wid = 16'(fw);
        c.filter_hei = 16'(fh);
        c.data_wid   = 16'(fw + pick(4));
        c.data_hei   = 16'(fh + pick(4));
        c.data_ch    = 16'((ch > 0) ? ch : 1 + pick(9));    // 0 picks at random
        c.filter_num = 16'((fn > 0) ? fn : 1 + pick(9));
        return c;
    endfunction

    // rough upper bound of one layer in cycles
    function automatic int layer_cycles(input conv_cfg_t c);
        int in_size;
        int blocks;
        in_size = int'(c.data_wid) * int'(c.data_hei);
        blocks  = ((int'(c.filter_num) + N_PE - 1) / N_PE) * ((int'(c.data_ch) + N_PE - 1) / N_PE);
        return blocks * (N_PE * (int'(c.filter_wid) * int'(c.filter_hei) + 1) + in_size + 20) + 10;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // reference model of one layer
    //////////////////////////////////////////////////////////////////////
    function automatic void build_expected(input conv_cfg_t c);
        int dw;
        int dh;
        int ch;
        int fn;
        int in_size;
        int o_size;
        int f_size;
        int win;
        int stride;
        int fbn;
        int cbn;
        int nf;
        int nc;
        int kbase [N_BUF];
        dw      = int'(c.data_wid);
        dh      = int'(c.data_hei);
        ch      = int'(c.data_ch);
        fn      = int'(c.filter_num);
        in_size = dw * dh;
        o_size  = (dw - int'(c.filter_wid) + 1) * (dh - int'(c.filter_hei) + 1);
        f_size  = int'(c.filter_wid) * int'(c.filter_hei);
        win     = (int'(c.filter_hei) - 1) * dw + int'(c.filter_wid);
        stride  = f_size * fn;
        fbn     = (fn + N_PE - 1) / N_PE;
        cbn     = (ch + N_PE - 1) / N_PE;
        for (int b = 0; b < N_BUF; b++) begin
            kbase[b] = in_size * (ch / N_PE + ((b < ch % N_PE) ? 1 : 0));   // after all images
        end
        kq.delete();
        iq.delete();
        wq.delete();
        rq.delete();
        exp_sf   = 0;
        exp_sl   = 0;
        exp_mac  = 0;
        exp_fe   = 0;
        exp_nl   = 0;
        got_sf   = 0;
        got_sl   = 0;
        got_mac  = 0;
        got_fe   = 0;
        got_nl   = 0;
        done_cnt = 0;
        for (int fb = 0; fb < fbn; fb++) begin
            nf = (fn - N_PE * fb < N_PE) ? fn - N_PE * fb : N_PE;
            for (int cb = 0; cb < cbn; cb++) begin
                nc = (ch - N_PE * cb < N_PE) ? ch - N_PE * cb : N_PE;
                for (int f = 0; f < nf; f++)
                    for (int k = 0; k < f_size; k++)
                        for (int b = 0; b < nc; b++)
                            kq.push_back({16'(b), 16'(kbase[b] + stride * cb
                                          + f_size * (N_PE * fb + f) + k)});
                for (int i = 0; i < in_size; i++)
                    for (int b = 0; b < nc; b++)
                        iq.push_back({16'(b), 16'(in_size * cb + i)});
                for (int i = 0; i < o_size; i++) begin
                    for (int b = 0; b < nf; b++) begin
                        wq.push_back({16'(b), 16'(o_size * fb + i)});
                        if (cb > 0) rq.push_back({16'(b), 16'(o_size * fb + i)});
                    end
                end
                exp_sf  += f_size * nf * nc;
                exp_sl  += in_size * nf * nc;
                exp_mac += (in_size - win) * nf * nc;
                if (cb > 0) exp_fe += o_size * nf;          // feedback from cb 1 on
                if (cb == cbn - 1) exp_nl += o_size * nf;
            end
        end
    endfunction

    function automatic string port_name(input int kind);
        case (kind)
            0:       return "kernel read";
            1:       return "image read";
            2:       return "psum write";
            default: return "feedback read";
        endcase
    endfunction

    function automatic void check_beat(input int kind, input int b, input logic [15:0] addr);
        logic [31:0] want;
        logic [31:0] got;
        got  = {16'(b), addr};
        want = '1;
        case (kind)
            0:       if (kq.size() != 0) want = kq.pop_front();
            1:       if (iq.size() != 0) want = iq.pop_front();
            2:       if (wq.size() != 0) want = wq.pop_front();
            default: if (rq.size() != 0) want = rq.pop_front();
        endcase
        if (want == '1) begin
            errors++;
            $display("[FAIL] %0t: unexpected %s on bank %0d", $time, port_name(kind), b);
        end else if (got != want) begin
            errors++;
            $display("[FAIL] %0t: %s bank %0d addr %0d, expected bank %0d addr %0d",
                     $time, port_name(kind), b, addr, want[31:16], want[15:0]);
        end
    endfunction

    function automatic void check_total(input string what, input int got, input int want);
        if (got != want) begin
            errors++;
            $display("[FAIL] %0t: %s count %0d, expected %0d", $time, what, got, want);
        end
    endfunction

    // compare every beat at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            for (int b = 0; b < N_BUF; b++) begin
                if (buf1_rd.en[b] && pe_feed.line_buffer_reset) check_beat(0, b, buf1_rd.addr[b]);
                if (buf1_rd.en[b] && !pe_feed.line_buffer_reset) check_beat(1, b, buf1_rd.addr[b]);
                if (buf2_wr.en[b]) check_beat(2, b, buf2_wr.addr[b]);
                if (buf2_rd.en[b]) check_beat(3, b, buf2_rd.addr[b]);
            end
            got_sf  += $countones(pe_feed.shift_filter);
            got_sl  += $countones(pe_feed.shift_line);
            got_mac += $countones(pe_feed.mac_en);
            got_fe  += $countones(pe_psum.feedback_en);
            got_nl  += $countones(pe_psum.nl_en);
            if (done) done_cnt++;
        end
    end

    task automatic run_layer(input int n, input bit poke);
        @(posedge clk);
        cfg <= cfgs[n];
        @(posedge clk);
        build_expected(cfgs[n]);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        if (poke) begin    // second start while busy
            repeat (4) @(posedge clk);
            start <= 1'b1;
            @(posedge clk);
            start <= 1'b0;
        end
        while (done_cnt == 0) @(posedge clk);
        repeat (20) @(posedge clk);
        check_total("done", done_cnt, 1);
        check_total("shift_filter", got_sf, exp_sf);
        check_total("shift_line", got_sl, exp_sl);
        check_total("mac_en", got_mac, exp_mac);
        check_total("feedback_en", got_fe, exp_fe);
        check_total("nl_en", got_nl, exp_nl);
        if (kq.size() + iq.size() + wq.size() + rq.size() != 0) begin
            errors++;
            $display("layer %0d ended with %0d buffer beats never issued", n,
                     kq.size() + iq.size() + wq.size() + rq.size());
        end
    endtask

    initial begin : watchdog
        wait (budget_cycles > 0);
        repeat (budget_cycles) @(posedge clk);
        $display("timeout: layers did not finish within %0d cycles", budget_cycles);
        $display("sim failed");
        $finish;
    end

    initial begin
        start <= 1'b0;
        cfg   <= '0;
        seed   = 32'h2621;
        errors = 0;
        cfgs[0] = make_cfg(4, 8);    // full blocks only
        cfgs[1] = make_cfg(6, 5);
        for (int n = 2; n < N_CFG; n++) cfgs[n] = make_cfg(0, 0);
        budget_cycles = 0;
        for (int n = 0; n < N_CFG; n++) budget_cycles += 4 * layer_cycles(cfgs[n]);
        budget_cycles += 200;

        wait (rst == 1'b0);
        @(negedge clk);
        if (done || !pe_feed.line_buffer_reset || buf1_rd.en != '0 || buf2_wr.en != '0
                || buf2_rd.en != '0 || pe_feed.shift_filter != '0
                || pe_feed.shift_line != '0 || pe_feed.mac_en != '0
                || pe_psum != '0) begin
            errors++;
            $display("[FAIL] %0t: outputs not in their reset state after reset", $time);
        end

        for (int n = 0; n < N_CFG; n++) run_layer(n, n % 2 == 1);

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: build.f
logic/conv_pkg.sv
logic/conv_geometry.sv
logic/kernel_loader.sv
logic/image_feeder.sv
logic/conv_loop_seq.sv
logic/row_gated_phase.sv
logic/psum_path.sv
logic/conv_ctrl_top.sv
testbench/tb_clock.sv
testbench/conv_ctrl_tb.sv

// File: Makefile
TOP = conv_ctrl_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f build.f --top-module $(TOP)

obj_dir/V$(TOP): build.f logic/*.sv testbench/*.sv
	verilator --binary --timing -f build.f --top-module $(TOP) -Mdir obj_dir

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^sim passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
